// ==== vlog.f ====
source/uart_pkg.sv
source/uart_regs.sv
source/uart_baud_gen.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_core.sv
sim/uart_sva.sv
sim/uart_checker.sv
sim/uart_tb.sv

// ==== sim/uart_tb.sv ====
`timescale 1ns/1ns
module uart_tb;
  import uart_pkg::*;

  localparam logic [DIV_W-1:0] RESET_DIV = 16'd3;
  // 40 frames of 160 oversample ticks at divisor 4 and some margin
  localparam int TIMEOUT_CYCLES = 40 * 160 * 4 + 2000;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        wr;
  logic        rd;
  uart_reg_e   addr;
  logic [7:0]  wdata;
  logic [7:0]  rdata;
  logic        tx;
  logic [7:0]  exp_mask;
  logic [7:0]  exp_val;
  logic [31:0] lfsr_state;
  int          err_cnt;
  int          frame_cnt;
  int          read_cnt;
  int          pending_cnt;

  always #2 clk = ~clk;

  // Serial output looped back into the receiver
  uart_core #(
    .RESET_DIVISOR(RESET_DIV)
  ) u_dut (
    .clk_i   (clk),
    .rst_n_i (rst_n),
    .wr_i    (wr),
    .rd_i    (rd),
    .addr_i  (addr),
    .wdata_i (wdata),
    .rdata_o (rdata),
    .tx_o    (tx),
    .rx_i    (tx)
  );

  bind uart_core uart_sva u_sva (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .divisor_i   (divisor),
    .os_tick_i   (os_tick),
    .tx_i        (tx_o),
    .tx_state_i  (u_tx.state_q)
  );

  uart_checker #(
    .RESET_DIVISOR(RESET_DIV)
  ) u_checker (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .wr_i       (wr),
    .rd_i       (rd),
    .addr_i     (addr),
    .wdata_i    (wdata),
    .rdata_i    (rdata),
    .tx_i       (tx),
    .exp_mask_i (exp_mask),
    .exp_val_i  (exp_val),
    .errors_o   (err_cnt),
    .frames_o   (frame_cnt),
    .reads_o    (read_cnt),
    .pending_o  (pending_cnt)
  );

  // ------------------------------
  // Random source
  // ------------------------------
  // Right-shifting Galois LFSR
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One step per bit taken
  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[6:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // ------------------------------
  // Bus access
  // ------------------------------
  task automatic write_reg(input uart_reg_e a, input logic [7:0] d);
    @(negedge clk);
    wr    = 1'b1;
    addr  = a;
    wdata = d;
    @(negedge clk);
    wr    = 1'b0;
  endtask

  // Mask of zero leaves the compare to the checker's own model, or skips it
  task automatic read_reg(input uart_reg_e a, input logic [7:0] mask,
                          input logic [7:0] exp, output logic [7:0] d);
    @(negedge clk);
    rd       = 1'b1;
    addr     = a;
    exp_mask = mask;
    exp_val  = exp;
    @(negedge clk);
    rd       = 1'b0;
    exp_mask = 8'h00;
    d        = rdata;
  endtask

  // Repeat LSR reads until one status bit is set
  task automatic poll_lsr(input int bit_idx, input logic [7:0] mask, input logic [7:0] exp);
    logic [7:0] d;
    d = 8'h00;
    while (!d[bit_idx]) read_reg(REG_LSR, mask, exp, d);
  endtask

  task automatic set_divisor(input logic [DIV_W-1:0] dv);
    // Line must be quiet before the bit time changes
    poll_lsr(LSR_TEMT, 8'h00, 8'h00);
    write_reg(REG_LCR, 8'h80);
    write_reg(REG_RBR_THR, dv[7:0]);
    write_reg(REG_DLM_IER, dv[DIV_W-1:8]);
    write_reg(REG_LCR, 8'h00);
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------
  initial begin : stimulus
    logic [7:0]       d;
    logic [DIV_W-1:0] dv;
    int               sva_cnt;
    lfsr_state = 32'hbc33_0912;
    rst_n    = 1'b0;
    wr       = 1'b0;
    rd       = 1'b0;
    addr     = REG_RBR_THR;
    wdata    = 8'h00;
    exp_mask = 8'h00;
    exp_val  = 8'h00;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    // Reset state has only THRE and TEMT set and the reset divisor
    read_reg(REG_LSR, 8'h63, 8'h60, d);
    write_reg(REG_LCR, 8'h80);
    read_reg(REG_RBR_THR, 8'hff, RESET_DIV[7:0], d);
    read_reg(REG_DLM_IER, 8'hff, RESET_DIV[DIV_W-1:8], d);
    write_reg(REG_LCR, 8'h00);

    // Loopback over random divisors 1 to 4
    for (int i = 0; i < 4; i++) begin
      dv = DIV_W'(rand_bits(2)) + 1'b1;
      set_divisor(dv);
      for (int j = 0; j < 4; j++) begin
        write_reg(REG_RBR_THR, rand_bits(8));
        poll_lsr(LSR_DR, 8'h00, 8'h00);
        read_reg(REG_RBR_THR, 8'h00, 8'h00, d);
      end
    end

    // Back to back with the second byte waiting in THR
    write_reg(REG_RBR_THR, rand_bits(8));
    poll_lsr(LSR_THRE, 8'h00, 8'h00);
    write_reg(REG_RBR_THR, rand_bits(8));
    read_reg(REG_LSR, 8'h60, 8'h00, d);
    poll_lsr(LSR_DR, 8'h00, 8'h00);
    read_reg(REG_RBR_THR, 8'h00, 8'h00, d);
    poll_lsr(LSR_DR, 8'h00, 8'h00);
    read_reg(REG_RBR_THR, 8'h00, 8'h00, d);

    // Overrun when two bytes land without an RBR read
    write_reg(REG_RBR_THR, rand_bits(8));
    poll_lsr(LSR_THRE, 8'h00, 8'h00);
    write_reg(REG_RBR_THR, rand_bits(8));
    poll_lsr(LSR_DR, 8'h00, 8'h00);
    // DR stays up while OE is awaited
    poll_lsr(LSR_OE, 8'h01, 8'h01);
    // Previous LSR read cleared OE
    read_reg(REG_LSR, 8'h03, 8'h01, d);
    read_reg(REG_RBR_THR, 8'h00, 8'h00, d);
    poll_lsr(LSR_TEMT, 8'h00, 8'h00);

    sva_cnt = u_dut.u_sva.fail_cnt;
    if (pending_cnt != 0) begin
      $display("%0d bytes written to THR never appeared on tx_o", pending_cnt);
    end
    $display("Errors: checker %0d, assertions %0d, missing frames %0d (frames %0d, reads %0d)",
             err_cnt, sva_cnt, pending_cnt, frame_cnt, read_cnt);
    if (err_cnt == 0 && sva_cnt == 0 && pending_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Cycle limit
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("The run timed out after %0d cycles without finishing the tests", cycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== sim/uart_checker.sv ====
`timescale 1ns/1ns
module uart_checker #(
  parameter logic [uart_pkg::DIV_W-1:0] RESET_DIVISOR = 1
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                wr_i,
  input  logic                rd_i,
  input  uart_pkg::uart_reg_e addr_i,
  input  logic [7:0]          wdata_i,
  input  logic [7:0]          rdata_i,
  input  logic                tx_i,
  input  logic [7:0]          exp_mask_i,
  input  logic [7:0]          exp_val_i,
  output int                  errors_o,
  output int                  frames_o,
  output int                  reads_o,
  output int                  pending_o
);
  import uart_pkg::*;

  logic [DIV_W-1:0] div_model;
  logic             dlab;
  // Read issued on the last rising edge
  logic             rd_pend;
  uart_reg_e        rd_addr;
  logic             rd_dlab;
  logic [7:0]       rd_mask;
  logic [7:0]       rd_val;
  // Bytes written to THR, then bytes seen on the line
  logic [7:0]       tx_q[$];
  logic [7:0]       rx_q[$];
  int               err_cnt = 0;
  int               frame_cnt = 0;
  int               read_cnt = 0;
  int               pend_cnt = 0;

  assign errors_o  = err_cnt;
  assign frames_o  = frame_cnt;
  assign reads_o   = read_cnt;
  assign pending_o = pend_cnt;

  // Start bit at bit 0, data LSB first, stop bit on top
  function automatic logic [9:0] expected_frame(input logic [7:0] b);
    return {1'b1, b, 1'b0};
  endfunction

  // ------------------------------
  // Register port model
  // ------------------------------
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      div_model <= RESET_DIVISOR;
      dlab      <= 1'b0;
      rd_pend   <= 1'b0;
    end else begin
      rd_pend <= rd_i;
      rd_addr <= addr_i;
      rd_dlab <= dlab;
      rd_mask <= exp_mask_i;
      rd_val  <= exp_val_i;
      if (wr_i) begin
        case (addr_i)
          REG_RBR_THR: begin
            if (dlab) begin
              div_model[7:0] <= wdata_i;
            end else begin
              tx_q.push_back(wdata_i);
              pend_cnt++;
            end
          end
          REG_DLM_IER: if (dlab) div_model[DIV_W-1:8] <= wdata_i;
          REG_LCR:     dlab <= wdata_i[7];
          default:     ;
        endcase
      end
    end
  end

  // Unread bytes get overwritten, so RBR holds the newest one
  task automatic check_rbr(input logic [7:0] got);
    logic [7:0] exp;
    if (rx_q.size() == 0) begin
      $display("ERROR at %0t: RBR read while no byte was received", $time);
      err_cnt++;
    end else begin
      exp = rx_q[$];
      rx_q.delete();
      if (got !== exp) begin
        $display("MISMATCH at %0t: RBR read 0x%02h, expected 0x%02h", $time, got, exp);
        err_cnt++;
      end
    end
  endtask

  // Read data is stable by the next falling edge
  always @(negedge clk_i) begin
    if (rst_n_i && rd_pend) begin
      read_cnt++;
      if (rd_addr == REG_RBR_THR && !rd_dlab) begin
        check_rbr(rdata_i);
      end else if ((rdata_i & rd_mask) !== (rd_val & rd_mask)) begin
        $display("MISMATCH at %0t: register %0d read 0x%02h, expected 0x%02h mask 0x%02h",
                 $time, rd_addr, rdata_i, rd_val, rd_mask);
        err_cnt++;
      end
    end
  end

  // ------------------------------
  // Frame decoder on tx_o
  // ------------------------------
  initial begin : frame_decode
    logic [9:0] got;
    logic [9:0] exp;
    logic [7:0] byte_exp;
    int         d;
    forever begin
      @(negedge clk_i);
      if (rst_n_i && tx_i === 1'b0) begin
        d = (div_model == '0) ? 1 : int'(div_model);
        // Half a bit to the start-bit centre
        repeat (OVERSAMPLE / 2 * d) @(negedge clk_i);
        for (int i = 0; i < 10; i++) begin
          got[i] = tx_i;
          if (i < 9) repeat (OVERSAMPLE * d) @(negedge clk_i);
        end
        if (tx_q.size() == 0) begin
          $display("ERROR at %0t: frame on tx_o with no byte written to THR", $time);
          err_cnt++;
        end else begin
          byte_exp = tx_q.pop_front();
          pend_cnt--;
          exp = expected_frame(byte_exp);
          if (got !== exp) begin
            $display("MISMATCH at %0t: frame %b, expected %b", $time, got, exp);
            err_cnt++;
          end
          // Loopback, so the receiver gets the same byte
          rx_q.push_back(byte_exp);
          frame_cnt++;
        end
      end
    end
  end

endmodule

// ==== sim/uart_sva.sv ====
`timescale 1ns/1ns
module uart_sva (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic [uart_pkg::DIV_W-1:0] divisor_i,
  input  logic                       os_tick_i,
  input  logic                       tx_i,
  input  uart_pkg::tx_state_e        tx_state_i
);
  import uart_pkg::*;

  // Assertion failures so far
  int               fail_cnt = 0;
  logic [DIV_W-1:0] div_last_q;
  logic [DIV_W-1:0] gap_q;
  logic             armed_q;
  logic [DIV_W-1:0] div_eff;

  // Zero divisor runs as one
  assign div_eff = (divisor_i == '0) ? DIV_W'(1) : divisor_i;

  // Cycles since the last oversample tick
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      div_last_q <= '0;
      gap_q      <= '0;
      armed_q    <= 1'b0;
    end else begin
      div_last_q <= divisor_i;
      // First tick after a divisor change only arms the check
      if (divisor_i != div_last_q) armed_q <= 1'b0;
      else if (os_tick_i) armed_q <= 1'b1;
      gap_q <= os_tick_i ? DIV_W'(1) : gap_q + 1'b1;
    end
  end

  // ------------------------------
  // Tick spacing
  // ------------------------------
  a_os_tick_spacing: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (os_tick_i && armed_q && divisor_i == div_last_q) |-> (gap_q == div_eff))
    else begin
      fail_cnt++;
      $error("os_tick spacing %0d, divisor %0d", gap_q, div_eff);
    end

  // ------------------------------
  // Idle line level
  // ------------------------------
  a_idle_high: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (tx_state_i == TX_IDLE) |-> tx_i)
    else begin
      fail_cnt++;
      $error("tx_o low while transmitter idle");
    end

endmodule

// ==== source/uart_core.sv ====
`timescale 1ns/1ns
module uart_core #(
  parameter logic [uart_pkg::DIV_W-1:0] RESET_DIVISOR = 1
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                wr_i,
  input  logic                rd_i,
  input  uart_pkg::uart_reg_e addr_i,
  input  logic [7:0]          wdata_i,
  output logic [7:0]          rdata_o,
  output logic                tx_o,
  input  logic                rx_i
);
  import uart_pkg::*;

  logic [DIV_W-1:0] divisor;
  logic             os_tick;
  logic             baud_tick;
  logic             tx_start;
  logic [7:0]       tx_data;
  logic             tx_busy;
  logic             rx_valid;
  logic [7:0]       rx_data;

  // Register file and line status
  uart_regs #(
    .RESET_DIVISOR(RESET_DIVISOR)
  ) u_regs (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .wr_i       (wr_i),
    .rd_i       (rd_i),
    .addr_i     (addr_i),
    .wdata_i    (wdata_i),
    .rdata_o    (rdata_o),
    .divisor_o  (divisor),
    .tx_start_o (tx_start),
    .tx_data_o  (tx_data),
    .tx_busy_i  (tx_busy),
    .rx_valid_i (rx_valid),
    .rx_data_i  (rx_data)
  );

  // Tick enables, everything stays on clk_i
  uart_baud_gen u_baud_gen (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .divisor_i   (divisor),
    .os_tick_o   (os_tick),
    .baud_tick_o (baud_tick)
  );

  uart_tx u_tx (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .baud_tick_i (baud_tick),
    .tx_start_i  (tx_start),
    .tx_data_i   (tx_data),
    .tx_busy_o   (tx_busy),
    .tx_o        (tx_o)
  );

  uart_rx u_rx (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .os_tick_i  (os_tick),
    .rx_i       (rx_i),
    .rx_valid_o (rx_valid),
    .rx_data_o  (rx_data)
  );

endmodule

// ==== source/uart_rx.sv ====
`timescale 1ns/1ns
module uart_rx (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       os_tick_i,
  input  logic       rx_i,
  output logic       rx_valid_o,
  output logic [7:0] rx_data_o
);
  import uart_pkg::*;

  localparam int OS_W = $clog2(OVERSAMPLE);
  // Half a bit to the start-bit centre, one bit after that
  localparam logic [OS_W-1:0] HALF_LAST = OS_W'(OVERSAMPLE / 2 - 1);
  localparam logic [OS_W-1:0] FULL_LAST = OS_W'(OVERSAMPLE - 1);

  rx_state_e       state_q;
  logic [1:0]      sync_q;
  logic            rx_s;
  logic [OS_W-1:0] os_cnt_q;
  logic [2:0]      bit_cnt_q;
  logic [7:0]      shift_q;

  // Two flop synchronizer, line idles high
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync_q <= 2'b11;
    end else begin
      sync_q <= {sync_q[0], rx_i};
    end
  end

  assign rx_s      = sync_q[1];
  assign rx_data_o = shift_q;

  // ------------------------------
  // Receive FSM
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= RX_IDLE;
      os_cnt_q   <= '0;
      bit_cnt_q  <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          if (!rx_s) begin
            state_q  <= RX_START;
            os_cnt_q <= '0;
          end
        end
        RX_START: begin
          if (os_tick_i) begin
            if (os_cnt_q == HALF_LAST) begin
              // Glitch filter, still low at the centre
              state_q   <= rx_s ? RX_IDLE : RX_DATA;
              os_cnt_q  <= '0;
              bit_cnt_q <= '0;
            end else begin
              os_cnt_q <= os_cnt_q + 1'b1;
            end
          end
        end
        RX_DATA: begin
          if (os_tick_i) begin
            os_cnt_q <= os_cnt_q + 1'b1;
            if (os_cnt_q == FULL_LAST) begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
              if (bit_cnt_q == 3'd7) state_q <= RX_STOP;
            end
          end
        end
        RX_STOP: begin
          if (os_tick_i) begin
            os_cnt_q <= os_cnt_q + 1'b1;
            if (os_cnt_q == FULL_LAST) begin
              // Bad stop bit drops the byte
              rx_valid_o <= rx_s;
              state_q    <= RX_IDLE;
            end
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // Mid-bit sample, LSB arrives first
  always_ff @(posedge clk_i) begin
    if (state_q == RX_DATA && os_tick_i && os_cnt_q == FULL_LAST) begin
      shift_q <= {rx_s, shift_q[7:1]};
    end
  end

endmodule

// ==== source/uart_tx.sv ====
`timescale 1ns/1ns
module uart_tx (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       baud_tick_i,
  input  logic       tx_start_i,
  input  logic [7:0] tx_data_i,
  output logic       tx_busy_o,
  output logic       tx_o
);
  import uart_pkg::*;

  tx_state_e  state_q;
  logic [7:0] shift_q;
  logic [2:0] bit_cnt_q;
  // Byte latched, waiting for a baud tick
  logic       pend_q;

  // Busy drops on the tick that ends the stop bit
  // so a held byte can follow without a gap
  assign tx_busy_o = pend_q ||
                     ((state_q != TX_IDLE) && !((state_q == TX_STOP) && baud_tick_i));

  always_ff @(posedge clk_i) begin
    if (tx_start_i) begin
      shift_q <= tx_data_i;
    end else if (baud_tick_i && (state_q == TX_START || state_q == TX_DATA)) begin
      // LSB first
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

  // ------------------------------
  // Frame FSM
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= TX_IDLE;
      pend_q    <= 1'b0;
      bit_cnt_q <= '0;
      tx_o      <= 1'b1;
    end else begin
      case (state_q)
        TX_IDLE: begin
          if (tx_start_i || pend_q) begin
            if (baud_tick_i) begin
              state_q <= TX_START;
              pend_q  <= 1'b0;
              tx_o    <= 1'b0;
            end else begin
              pend_q  <= 1'b1;
            end
          end
        end
        TX_START: begin
          if (baud_tick_i) begin
            state_q   <= TX_DATA;
            bit_cnt_q <= '0;
            tx_o      <= shift_q[0];
          end
        end
        TX_DATA: begin
          if (baud_tick_i) begin
            if (bit_cnt_q == 3'd7) begin
              state_q <= TX_STOP;
              tx_o    <= 1'b1;
            end else begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
              tx_o      <= shift_q[0];
            end
          end
        end
        TX_STOP: begin
          // Back to back frame starts right here
          if (baud_tick_i) begin
            state_q <= tx_start_i ? TX_START : TX_IDLE;
            tx_o    <= !tx_start_i;
          end
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

endmodule

// ==== source/uart_baud_gen.sv ====
`timescale 1ns/1ns
module uart_baud_gen (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic [uart_pkg::DIV_W-1:0] divisor_i,
  output logic                       os_tick_o,
  output logic                       baud_tick_o
);
  import uart_pkg::*;

  localparam int OS_W = $clog2(OVERSAMPLE);
  localparam logic [OS_W-1:0] OS_LAST = OS_W'(OVERSAMPLE - 1);

  logic [DIV_W-1:0] div_q;
  logic [DIV_W-1:0] div_eff;
  logic [DIV_W-1:0] os_cnt_q;
  logic [OS_W-1:0]  tick_cnt_q;

  // Zero divisor behaves as one
  assign div_eff = (divisor_i == '0) ? DIV_W'(1) : divisor_i;

  // ------------------------------
  // Oversample and baud enables
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      div_q       <= '0;
      os_cnt_q    <= '0;
      tick_cnt_q  <= '0;
      os_tick_o   <= 1'b0;
      baud_tick_o <= 1'b0;
    end else if (divisor_i != div_q) begin
      // New divisor, restart both counters
      div_q       <= divisor_i;
      os_cnt_q    <= div_eff - 1'b1;
      tick_cnt_q  <= '0;
      os_tick_o   <= 1'b0;
      baud_tick_o <= 1'b0;
    end else if (os_cnt_q == '0) begin
      // One pulse per divisor cycles
      os_cnt_q    <= div_eff - 1'b1;
      os_tick_o   <= 1'b1;
      // Every 16th oversample tick ends a bit
      baud_tick_o <= (tick_cnt_q == OS_LAST);
      tick_cnt_q  <= (tick_cnt_q == OS_LAST) ? '0 : tick_cnt_q + 1'b1;
    end else begin
      os_cnt_q    <= os_cnt_q - 1'b1;
      os_tick_o   <= 1'b0;
      baud_tick_o <= 1'b0;
    end
  end

endmodule

// ==== source/uart_regs.sv ====
`timescale 1ns/1ns
module uart_regs #(
  parameter logic [uart_pkg::DIV_W-1:0] RESET_DIVISOR = 1
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        wr_i,
  input  logic                        rd_i,
  input  uart_pkg::uart_reg_e         addr_i,
  input  logic [7:0]                  wdata_i,
  output logic [7:0]                  rdata_o,
  output logic [uart_pkg::DIV_W-1:0]  divisor_o,
  output logic                        tx_start_o,
  output logic [7:0]                  tx_data_o,
  input  logic                        tx_busy_i,
  input  logic                        rx_valid_i,
  input  logic [7:0]                  rx_data_i
);
  import uart_pkg::*;

  logic [DIV_W-1:0] div_q;
  logic             dlab_q;
  logic [7:0]       thr_q;
  logic             thr_full_q;
  logic [7:0]       rbr_q;
  logic             dr_q;
  logic             oe_q;
  logic [7:0]       lsr;
  logic             thr_wr;
  logic             rbr_rd;
  logic             lsr_rd;

  // ------------------------------
  // Address decode
  // ------------------------------
  // DLAB steers offset 0 and 1 to the divisor
  assign thr_wr = wr_i && (addr_i == REG_RBR_THR) && !dlab_q;
  assign rbr_rd = rd_i && (addr_i == REG_RBR_THR) && !dlab_q;
  assign lsr_rd = rd_i && (addr_i == REG_LSR);

  // Holding byte goes out once transmitter is free
  assign tx_start_o = thr_full_q && !tx_busy_i;
  assign tx_data_o  = thr_q;
  assign divisor_o  = div_q;

  // Line status
  always_comb begin
    lsr           = '0;
    lsr[LSR_DR]   = dr_q;
    lsr[LSR_OE]   = oe_q;
    lsr[LSR_THRE] = !thr_full_q;
    // Nothing held and nothing on the line
    lsr[LSR_TEMT] = !thr_full_q && !tx_busy_i;
  end

  // ------------------------------
  // Control registers
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      div_q  <= RESET_DIVISOR;
      dlab_q <= 1'b0;
    end else if (wr_i) begin
      case (addr_i)
        REG_RBR_THR: if (dlab_q) div_q[7:0] <= wdata_i;
        REG_DLM_IER: if (dlab_q) div_q[DIV_W-1:8] <= wdata_i;
        // Only DLAB kept in LCR
        REG_LCR:     dlab_q <= wdata_i[7];
        default:     ;
      endcase
    end
  end

  // Transmit holding register, writes while full are dropped
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      thr_full_q <= 1'b0;
    end else if (tx_start_o) begin
      thr_full_q <= 1'b0;
    end else if (thr_wr) begin
      thr_full_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (thr_wr && !thr_full_q) begin
      thr_q <= wdata_i;
    end
  end

  // ------------------------------
  // Receive side
  // ------------------------------
  // New byte always lands in RBR
  always_ff @(posedge clk_i) begin
    if (rx_valid_i) begin
      rbr_q <= rx_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      dr_q <= 1'b0;
      oe_q <= 1'b0;
    end else begin
      if (rx_valid_i) dr_q <= 1'b1;
      else if (rbr_rd) dr_q <= 1'b0;
      // Unread byte overwritten
      if (rx_valid_i && dr_q && !rbr_rd) oe_q <= 1'b1;
      else if (lsr_rd) oe_q <= 1'b0;
    end
  end

  // Registered read data
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rdata_o <= 8'h00;
    end else if (rd_i) begin
      case (addr_i)
        REG_RBR_THR: rdata_o <= dlab_q ? div_q[7:0] : rbr_q;
        REG_DLM_IER: rdata_o <= dlab_q ? div_q[DIV_W-1:8] : 8'h00;
        REG_LCR:     rdata_o <= {dlab_q, 7'b0};
        REG_LSR:     rdata_o <= lsr;
        default:     rdata_o <= 8'h00;
      endcase
    end
  end

endmodule

// ==== source/uart_pkg.sv ====
package uart_pkg;

  // Register map, 16550 layout
  typedef enum logic [2:0] {
    REG_RBR_THR = 3'd0,
    REG_DLM_IER = 3'd1,
    REG_LCR     = 3'd3,
    REG_LSR     = 3'd5
  } uart_reg_e;

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

  // Oversample ticks per bit
  localparam int OVERSAMPLE = 16;
  // Divisor width, DLM:DLL
  localparam int DIV_W = 16;

  // Line status bits
  localparam int LSR_DR   = 0;
  localparam int LSR_OE   = 1;
  localparam int LSR_THRE = 5;
  localparam int LSR_TEMT = 6;

endpackage
